/* common/frontend_config.svh */
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

////////////////////////////////////////
// Instruction buffer sizing
////////////////////////////////////////

// Power of two, at least 4
`define IBUF_DEPTH 16
`define IBUF_PTR_W 4

////////////////////////////////////////
// Fetch and datapath
////////////////////////////////////////

`define RESET_PC 32'h0000_0000
`define WORD_W 32

`endif

/* common/frontend_pkg.sv */
`include "frontend_config.svh"

package frontend_pkg;

    ////////////////////////////////////////
    // Decode and control encodings
    ////////////////////////////////////////

    // Instruction class from bits 31:26, unknown codes decode as ALU
    typedef enum logic [5:0] {
        OP_ALU    = 6'h00,
        OP_JUMP   = 6'h02,
        OP_BRANCH = 6'h04,
        OP_LOAD   = 6'h23,
        OP_STORE  = 6'h2b
    } opcode_e;

    // Fetch sequencing
    typedef enum logic {
        FS_RUN,
        FS_WAIT_CREDIT
    } fetch_state_e;

    ////////////////////////////////////////
    // Queue payload
    ////////////////////////////////////////

    // Prediction made at fetch, carried to issue
    typedef struct packed {
        logic              is_branch;
        logic              pred_taken;
        logic [`WORD_W-1:0] pred_target;
    } branch_info_t;

    // One instruction buffer slot
    typedef struct packed {
        logic [`WORD_W-1:0] inst;
        logic [`WORD_W-1:0] pc;
        branch_info_t       binfo;
    } ibuf_entry_t;

endpackage

/* common/fetch_if.sv */
// Fetch to instruction buffer, two slots per cycle plus credit return
interface fetch_if
    import frontend_pkg::*;
();

    // Slot 0 is the older one when both are valid
    logic        valid0;
    logic        valid1;
    ibuf_entry_t entry0;
    ibuf_entry_t entry1;

    // Entries freed by the buffer one cycle earlier, 0 to 2
    logic [1:0]  credit_ret;

    modport producer (
        output valid0,
        output valid1,
        output entry0,
        output entry1,
        input  credit_ret
    );

    modport buffer (
        input  valid0,
        input  valid1,
        input  entry0,
        input  entry1,
        output credit_ret
    );

endinterface

/* common/issue_if.sv */
// Instruction buffer head to issue stage
interface issue_if
    import frontend_pkg::*;
();

    // Two oldest entries, combinational from storage
    ibuf_entry_t head0;
    ibuf_entry_t head1;
    logic        head0_valid;
    logic        head1_valid;

    // Entries taken this cycle, 0 to 2
    logic [1:0]  pop;

    modport buffer (
        output head0,
        output head1,
        output head0_valid,
        output head1_valid,
        input  pop
    );

    modport consumer (
        input  head0,
        input  head1,
        input  head0_valid,
        input  head1_valid,
        output pop
    );

endinterface

/* fetch/fetch_unit.sv */
`include "frontend_config.svh"

module fetch_unit
    import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,
    output logic [31:0] imem_addr_o,
    input  logic [31:0] imem_rdata0_i,
    input  logic [31:0] imem_rdata1_i,
    fetch_if.producer   fq
);

    localparam int CNT_W = `IBUF_PTR_W + 1;

    fetch_state_e     state_q;
    logic [31:0]      pc_q;
    logic [31:0]      group_pc;
    logic [31:0]      next_pc;
    logic [CNT_W-1:0] credits_q;
    logic [CNT_W-1:0] credits_avail;
    logic [CNT_W-1:0] ret_ext;
    logic [CNT_W-1:0] need;
    logic [CNT_W-1:0] sent;
    logic             slot0_en;
    logic             slot1_en;
    logic             send;
    branch_info_t     info0;
    branch_info_t     info1;

    ////////////////////////////////////////
    // Predecode and static prediction
    ////////////////////////////////////////

    function automatic opcode_e decode_op(input logic [31:0] word);
        opcode_e op;
        case (word[31:26])
            OP_LOAD:   op = OP_LOAD;
            OP_STORE:  op = OP_STORE;
            OP_BRANCH: op = OP_BRANCH;
            OP_JUMP:   op = OP_JUMP;
            default:   op = OP_ALU;
        endcase
        return op;
    endfunction

    // Jumps always taken, conditional branches taken only backwards
    function automatic branch_info_t predict(input logic [31:0] word, input logic [31:0] pc);
        opcode_e      op;
        logic [31:0]  offset;
        branch_info_t info;
        op               = decode_op(word);
        offset           = {{14{word[15]}}, word[15:0], 2'b00};
        info.is_branch   = (op == OP_BRANCH) || (op == OP_JUMP);
        info.pred_taken  = (op == OP_JUMP) || ((op == OP_BRANCH) && word[15]);
        info.pred_target = pc + offset;
        return info;
    endfunction

    // Aligned two-word group
    assign group_pc    = {pc_q[31:3], 3'b000};
    assign imem_addr_o = group_pc;

    assign info0 = predict(imem_rdata0_i, group_pc);
    assign info1 = predict(imem_rdata1_i, group_pc + 32'd4);

    // Odd word start skips slot 0, taken slot 0 drops slot 1
    assign slot0_en = !pc_q[2];
    assign slot1_en = !(slot0_en && info0.pred_taken);

    always_comb begin
        if (slot0_en && info0.pred_taken) begin
            next_pc = info0.pred_target;
        end else if (info1.pred_taken) begin
            next_pc = info1.pred_target;
        end else begin
            next_pc = group_pc + 32'd8;
        end
    end

    ////////////////////////////////////////
    // Credit check
    ////////////////////////////////////////

    assign need    = (slot0_en && slot1_en) ? CNT_W'(2) : CNT_W'(1);
    assign ret_ext = CNT_W'(fq.credit_ret);

    // While stalled, credits coming back this cycle count at once
    assign credits_avail = (state_q == FS_WAIT_CREDIT) ? credits_q + ret_ext : credits_q;

    assign send = !rst_i && !redirect_i && (credits_avail >= need);
    assign sent = send ? need : '0;

    always_comb begin
        fq.valid0       = send && slot0_en;
        fq.valid1       = send && slot1_en;
        fq.entry0.inst  = imem_rdata0_i;
        fq.entry0.pc    = group_pc;
        fq.entry0.binfo = info0;
        fq.entry1.inst  = imem_rdata1_i;
        fq.entry1.pc    = group_pc + 32'd4;
        fq.entry1.binfo = info1;
    end

    ////////////////////////////////////////
    // PC, credits and state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q      <= `RESET_PC;
            credits_q <= CNT_W'(`IBUF_DEPTH);
            state_q   <= FS_RUN;
        end else if (redirect_i) begin
            // Returns in this cycle are dropped, the buffer empties too
            pc_q      <= redirect_pc_i;
            credits_q <= CNT_W'(`IBUF_DEPTH);
            state_q   <= FS_RUN;
        end else begin
            credits_q <= credits_q + ret_ext - sent;
            if (send) begin
                pc_q    <= next_pc;
                state_q <= FS_RUN;
            end else begin
                state_q <= FS_WAIT_CREDIT;
            end
        end
    end

endmodule

/* inst_buffer/inst_buffer.sv */
`include "frontend_config.svh"

module inst_buffer
    import frontend_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  logic    flush_i,
    fetch_if.buffer fq,
    issue_if.buffer iq
);

    localparam int CNT_W = `IBUF_PTR_W + 1;

    ibuf_entry_t            mem [`IBUF_DEPTH];
    logic [`IBUF_PTR_W-1:0] head_q;
    logic [`IBUF_PTR_W-1:0] tail_q;
    logic [`IBUF_PTR_W-1:0] head_p1;
    logic [`IBUF_PTR_W-1:0] tail_p1;
    logic [CNT_W-1:0]       count_q;
    logic [CNT_W-1:0]       push_cnt;
    logic [CNT_W-1:0]       pop_cnt;
    logic [1:0]             credit_ret_q;

    // Pointer arithmetic wraps at the depth
    assign head_p1 = head_q + 1'b1;
    assign tail_p1 = tail_q + 1'b1;

    assign push_cnt = CNT_W'(fq.valid0) + CNT_W'(fq.valid1);
    assign pop_cnt  = CNT_W'(iq.pop);

    ////////////////////////////////////////
    // Storage write
    ////////////////////////////////////////

    // Lone slot 1 goes to the tail like any single entry
    always_ff @(posedge clk) begin
        if (!flush_i) begin
            if (fq.valid0) begin
                mem[tail_q] <= fq.entry0;
                if (fq.valid1) begin
                    mem[tail_p1] <= fq.entry1;
                end
            end else if (fq.valid1) begin
                mem[tail_q] <= fq.entry1;
            end
        end
    end

    ////////////////////////////////////////
    // Head view
    ////////////////////////////////////////

    assign iq.head0       = mem[head_q];
    assign iq.head1       = mem[head_p1];
    assign iq.head0_valid = (count_q >= CNT_W'(1));
    assign iq.head1_valid = (count_q >= CNT_W'(2));

    ////////////////////////////////////////
    // Pointers, occupancy, credits
    ////////////////////////////////////////

    // Flush drops occupancy only, storage is left as is
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            credit_ret_q <= '0;
        end else begin
            tail_q       <= tail_q + push_cnt[`IBUF_PTR_W-1:0];
            head_q       <= head_q + pop_cnt[`IBUF_PTR_W-1:0];
            count_q      <= count_q + push_cnt - pop_cnt;
            // One credit per freed entry, seen by fetch next cycle
            credit_ret_q <= iq.pop;
        end
    end

    assign fq.credit_ret = credit_ret_q;

endmodule

/* hdl/issue_stage.sv */
`include "frontend_config.svh"

module issue_stage
    import frontend_pkg::*;
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic               issue_ready_i,
    issue_if.consumer          iq,
    output logic               issue_valid0_o,
    output logic [`WORD_W-1:0] issue_inst0_o,
    output logic [`WORD_W-1:0] issue_pc0_o,
    output logic               issue_taken0_o,
    output logic               issue_valid1_o,
    output logic [`WORD_W-1:0] issue_inst1_o,
    output logic [`WORD_W-1:0] issue_pc1_o,
    output logic               issue_taken1_o
);

    logic fire;
    logic pair;

    ////////////////////////////////////////
    // Pairing and pop
    ////////////////////////////////////////

    // A branch or jump in slot 0 closes its group
    assign pair = iq.head0_valid && iq.head1_valid && !iq.head0.binfo.is_branch;
    assign fire = issue_ready_i && iq.head0_valid && !flush_i;

    always_comb begin
        if (!fire) begin
            iq.pop = 2'd0;
        end else if (pair) begin
            iq.pop = 2'd2;
        end else begin
            iq.pop = 2'd1;
        end
    end

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    // Valids last one cycle per issue
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            issue_valid0_o <= 1'b0;
            issue_valid1_o <= 1'b0;
        end else begin
            issue_valid0_o <= fire;
            issue_valid1_o <= fire && pair;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            issue_inst0_o  <= iq.head0.inst;
            issue_pc0_o    <= iq.head0.pc;
            issue_taken0_o <= iq.head0.binfo.pred_taken;
            issue_inst1_o  <= iq.head1.inst;
            issue_pc1_o    <= iq.head1.pc;
            issue_taken1_o <= iq.head1.binfo.pred_taken;
        end
    end

endmodule

/* hdl/frontend_top.sv */
`include "frontend_config.svh"

module frontend_top (
    input  logic               clk,
    input  logic               rst_i,

    // Instruction memory, combinational read
    output logic [31:0]        imem_addr_o,
    input  logic [31:0]        imem_rdata0_i,
    input  logic [31:0]        imem_rdata1_i,

    // Back end redirect
    input  logic               redirect_i,
    input  logic [31:0]        redirect_pc_i,

    input  logic               issue_ready_i,

    // Issued pair
    output logic               issue_valid0_o,
    output logic [`WORD_W-1:0] issue_inst0_o,
    output logic [`WORD_W-1:0] issue_pc0_o,
    output logic               issue_taken0_o,
    output logic               issue_valid1_o,
    output logic [`WORD_W-1:0] issue_inst1_o,
    output logic [`WORD_W-1:0] issue_pc1_o,
    output logic               issue_taken1_o
);

    fetch_if fq ();
    issue_if iq ();

    fetch_unit i_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata0_i (imem_rdata0_i),
        .imem_rdata1_i (imem_rdata1_i),
        .fq            (fq.producer)
    );

    // Redirect flushes the queue and the issue registers
    inst_buffer i_ibuf (
        .clk     (clk),
        .rst_i   (rst_i),
        .flush_i (redirect_i),
        .fq      (fq.buffer),
        .iq      (iq.buffer)
    );

    issue_stage i_issue (
        .clk            (clk),
        .rst_i          (rst_i),
        .flush_i        (redirect_i),
        .issue_ready_i  (issue_ready_i),
        .iq             (iq.consumer),
        .issue_valid0_o (issue_valid0_o),
        .issue_inst0_o  (issue_inst0_o),
        .issue_pc0_o    (issue_pc0_o),
        .issue_taken0_o (issue_taken0_o),
        .issue_valid1_o (issue_valid1_o),
        .issue_inst1_o  (issue_inst1_o),
        .issue_pc1_o    (issue_pc1_o),
        .issue_taken1_o (issue_taken1_o)
    );

endmodule

/* sim/frontend_tb.sv */
module frontend_tb
    import frontend_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int REC_WORDS  = 256;
    localparam int MEM_WORDS  = 1024;

    logic        clk;
    logic        rst_i;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata0;
    logic [31:0] imem_rdata1;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        issue_ready;
    logic        issue_valid0;
    logic [31:0] issue_inst0;
    logic [31:0] issue_pc0;
    logic        issue_taken0;
    logic        issue_valid1;
    logic [31:0] issue_inst1;
    logic [31:0] issue_pc1;
    logic        issue_taken1;

    // Test records are four words each, kind first
    logic [31:0] recs [REC_WORDS];
    logic [31:0] imem [MEM_WORDS];
    ibuf_entry_t expected [$];
    int          redir_after [$];
    logic [31:0] redir_pc [$];
    int          consumed;
    int          errors;
    int          stall_left;
    bit          loaded;

    frontend_top i_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .imem_addr_o    (imem_addr),
        .imem_rdata0_i  (imem_rdata0),
        .imem_rdata1_i  (imem_rdata1),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .issue_ready_i  (issue_ready),
        .issue_valid0_o (issue_valid0),
        .issue_inst0_o  (issue_inst0),
        .issue_pc0_o    (issue_pc0),
        .issue_taken0_o (issue_taken0),
        .issue_valid1_o (issue_valid1),
        .issue_inst1_o  (issue_inst1),
        .issue_pc1_o    (issue_pc1),
        .issue_taken1_o (issue_taken1)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Instruction memory model
    ////////////////////////////////////////

    // Unlisted words decode as ALU, opcode 6'h01
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h01, addr[27:2] ^ {22'h0, addr[31:28]}};
    endfunction

    always_comb begin
        imem_rdata0 = imem[imem_addr[11:2]];
        imem_rdata1 = imem[imem_addr[11:2] + 10'd1];
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic fail_and_stop(input string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic ibuf_entry_t pack_issue(input logic [31:0] inst, input logic [31:0] pc,
                                               input logic taken);
        ibuf_entry_t e;
        e                  = '0;
        e.inst             = inst;
        e.pc               = pc;
        e.binfo.pred_taken = taken;
        return e;
    endfunction

    task automatic check_entry(input ibuf_entry_t got, input ibuf_entry_t exp, input int idx);
        if (got.pc !== exp.pc || got.inst !== exp.inst ||
            got.binfo.pred_taken !== exp.binfo.pred_taken) begin
            fail_and_stop($sformatf("item %0d pc %h inst %h taken %b, expected %h %h %b",
                idx, got.pc, got.inst, got.binfo.pred_taken,
                exp.pc, exp.inst, exp.binfo.pred_taken));
        end
    endtask

    // A branch or jump in slot 0 closes the group
    task automatic check_pairing(input logic v0, input logic v1, input ibuf_entry_t slot0);
        opcode_e op;
        op = opcode_e'(slot0.inst[31:26]);
        if (v1 && !v0) begin
            fail_and_stop("slot 1 valid without slot 0");
        end else if (v0 && v1 && (op == OP_BRANCH || op == OP_JUMP)) begin
            fail_and_stop($sformatf("slot 1 paired behind branch at pc %h", slot0.pc));
        end
    endtask

    // Fetch reads whole aligned groups inside the modeled memory
    task automatic check_fetch_addr(input logic [31:0] addr);
        if (addr[2:0] !== 3'b000) begin
            fail_and_stop($sformatf("fetch address %h not group aligned", addr));
        end else if (addr >= 32'(MEM_WORDS * 4)) begin
            fail_and_stop($sformatf("fetch address %h outside memory", addr));
        end
    endtask

    task automatic check_no_issue(input logic v0, input logic v1, input string phase);
        if (v0 !== 1'b0 || v1 !== 1'b0) begin
            fail_and_stop($sformatf("issue valid high %s", phase));
        end
    endtask

    // Short random gaps plus occasional long stalls that fill the buffer
    task automatic drive_ready();
        if (stall_left > 0) begin
            stall_left--;
            issue_ready = 1'b0;
        end else if ($urandom_range(15) == 0) begin
            stall_left  = 20 + $urandom_range(20);
            issue_ready = 1'b0;
        end else begin
            issue_ready = ($urandom_range(3) != 0);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and stream checking
    ////////////////////////////////////////

    initial begin
        int          r;
        ibuf_entry_t exp_e;
        ibuf_entry_t got0;
        ibuf_entry_t got1;
        rst_i       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        issue_ready = 1'b0;
        consumed    = 0;
        errors      = 0;
        stall_left  = 0;
        loaded      = 1'b0;
        void'($urandom(3782));
        for (int a = 0; a < MEM_WORDS; a++) begin
            imem[a] = fill_word(32'(a * 4));
        end
        $readmemh("sim/frontend_tests.txt", recs);
        r = 0;
        while (r < REC_WORDS && recs[r] >= 32'd1 && recs[r] <= 32'd3) begin
            case (recs[r])
                32'd1: imem[recs[r+1][11:2]] = recs[r+2];
                32'd2: begin
                    redir_after.push_back(int'(recs[r+1]));
                    redir_pc.push_back(recs[r+2]);
                end
                default: begin
                    exp_e = pack_issue(recs[r+2], recs[r+1], recs[r+3][0]);
                    expected.push_back(exp_e);
                end
            endcase
            r += 4;
        end
        if (expected.size() == 0) begin
            fail_and_stop("no expected items found in sim/frontend_tests.txt");
        end
        loaded = 1'b1;

        repeat (5) begin
            @(posedge clk);
            #1;
            check_no_issue(issue_valid0, issue_valid1, "during reset");
        end
        #1 rst_i = 1'b0;
        @(posedge clk);
        #1;
        check_no_issue(issue_valid0, issue_valid1, "right after reset");
        #1 drive_ready();

        while (consumed < expected.size()) begin
            @(posedge clk);
            #1;
            check_fetch_addr(imem_addr);
            got0 = pack_issue(issue_inst0, issue_pc0, issue_taken0);
            got1 = pack_issue(issue_inst1, issue_pc1, issue_taken1);
            check_pairing(issue_valid0, issue_valid1, got0);
            if (issue_valid0) begin
                check_entry(got0, expected[consumed], consumed);
                consumed++;
            end
            if (issue_valid1 && consumed < expected.size()) begin
                check_entry(got1, expected[consumed], consumed);
                consumed++;
            end
            #1;
            // Redirect only on an exact group boundary, issue held off
            if (redir_after.size() > 0 && consumed == redir_after[0]) begin
                void'(redir_after.pop_front());
                redirect    = 1'b1;
                redirect_pc = redir_pc.pop_front();
                issue_ready = 1'b0;
            end else begin
                redirect = 1'b0;
                drive_ready();
            end
        end

        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, 100 cycles per expected item
    initial begin
        wait (loaded);
        repeat (100 * expected.size() + 10) @(posedge clk);
        $display("Watchdog timeout with %0d of %0d items issued", consumed, expected.size());
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* sim/frontend_tests.txt */
// Columns: kind a b c, hex. 1 memory (addr word 0), 2 redirect (after n items, pc, 0),
// 3 expected issue (pc inst taken), 0 end of records
1 00000000 00001000 0
1 00000004 8c001004 0
1 00000008 10000002 0
1 0000000c ac00100c 0
1 00000010 08000003 0
1 0000001c 0000101c 0
1 00000020 04001020 0
1 00000024 1000ffff 0
1 00000104 8c002104 0
1 00000108 0000ffff 0
1 0000010c 08000005 0
1 00000120 ac002120 0
1 00000124 10000007 0
1 00000128 1000fffe 0
2 0000000a 00000104 0
3 00000000 00001000 0
3 00000004 8c001004 0
3 00000008 10000002 0
3 0000000c ac00100c 0
3 00000010 08000003 1
3 0000001c 0000101c 0
3 00000020 04001020 0
3 00000024 1000ffff 1
3 00000020 04001020 0
3 00000024 1000ffff 1
3 00000104 8c002104 0
3 00000108 0000ffff 0
3 0000010c 08000005 1
3 00000120 ac002120 0
3 00000124 10000007 0
3 00000128 1000fffe 1
3 00000120 ac002120 0
0 0 0 0

/* build.f */
+incdir+common
common/frontend_pkg.sv
common/fetch_if.sv
common/issue_if.sv
fetch/fetch_unit.sv
inst_buffer/inst_buffer.sv
hdl/issue_stage.sv
hdl/frontend_top.sv
sim/frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
VFLAGS    ?= -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(SIM_LOG)
	@grep -q "^TEST PASSED$$" $(SIM_LOG) || { echo "Simulation failed, see $(SIM_LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
